//--- rtl/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// wishbone bus widths
`define ALU_WB_ADR_W        3
`define ALU_WB_DAT_W        16

// register map, r0 to r3 sit at 0 to 3
`define ALU_ADR_FLAGS       4
`define ALU_ADR_CMD         5
`define ALU_ADR_STATUS      6

// command word fields
`define ALU_CMD_OP_LSB      0   // 4-bit operation
`define ALU_CMD_USE_CARRY   4
`define ALU_CMD_DST_LSB     5   // 2-bit dst / a register
`define ALU_CMD_SRC_LSB     7   // 2-bit src / b register

// flag register bits
`define ALU_FLAG_CARRY      0
`define ALU_FLAG_ZERO       1
`define ALU_FLAG_DECIMAL    2

// status register bits
`define ALU_STATUS_BUSY     0

`endif

//--- rtl/types.sv
`default_nettype none

package types;

    // ALU operation codes, as carried in the command word
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_CP  = 4'd2,  // subtract, flags only
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_RRC = 4'd6,  // rotate right through carry
        ALU_RLC = 4'd7,  // rotate left through carry
        ALU_NOT = 4'd8
    } alu_op;

    // one data nibble of the core
    typedef logic [3:0] nibble_t;

    // selects r0 to r3
    typedef logic [1:0] reg_idx_t;

    // flag register layout
    //   bit 0 carry
    //   bit 1 zero
    //   bit 2 decimal
    typedef logic [2:0] flags_t;

    // execution sequencer states
    typedef enum logic [1:0] {
        EXEC_IDLE  = 2'd0,
        EXEC_RUN   = 2'd1,  // operands latched, alu evaluating
        EXEC_WRITE = 2'd2   // results registered, write-back
    } exec_state_t;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu (
    input  wire types::alu_op   op,
    input  wire                 op_use_carry,

    input  wire types::nibble_t temp_a,
    input  wire types::nibble_t temp_b,

    input  wire                 flag_carry_in,
    input  wire                 flag_decimal_in,

    output types::nibble_t      out,
    output logic                flag_carry_out,
    output logic                flag_zero_out
);

    logic       cin_add;
    logic       cin_sub;
    logic [4:0] sum;       // bit 4 is the carry
    logic [4:0] sum_adj;
    logic [4:0] diff;      // bit 4 is the borrow
    logic [4:0] diff_adj;

    assign cin_add = op_use_carry & flag_carry_in;
    // CP never takes the incoming carry
    assign cin_sub = (op == types::ALU_SUB) & op_use_carry & flag_carry_in;

    assign sum      = {1'b0, temp_a} + {1'b0, temp_b} + {4'b0, cin_add};
    assign sum_adj  = sum - 5'd10;     // bcd correction
    assign diff     = {1'b0, temp_a} - {1'b0, temp_b} - {4'b0, cin_sub};
    assign diff_adj = diff - 5'd6;     // bcd borrow correction

    always_comb begin
        out            = '0;
        flag_carry_out = flag_carry_in;   // kept unless the op changes it

        case (op)
            types::ALU_ADD: begin
                if (flag_decimal_in && sum >= 5'd10) begin
                    out            = sum_adj[3:0];
                    flag_carry_out = 1'b1;
                end else begin
                    {flag_carry_out, out} = sum;
                end
            end
            types::ALU_SUB, types::ALU_CP: begin
                if (flag_decimal_in && diff[4]) begin
                    out            = diff_adj[3:0];
                    flag_carry_out = 1'b1;
                end else begin
                    {flag_carry_out, out} = diff;
                end
            end
            types::ALU_AND: out = temp_a & temp_b;
            types::ALU_OR:  out = temp_a | temp_b;
            types::ALU_XOR: out = temp_a ^ temp_b;
            types::ALU_RRC: begin
                // carry into bit 3, bit 0 out to carry
                {out, flag_carry_out} = {flag_carry_in, temp_a};
            end
            types::ALU_RLC: begin
                // carry into bit 0, bit 3 out to carry
                {flag_carry_out, out} = {temp_a, flag_carry_in};
            end
            types::ALU_NOT: out = ~temp_a;
            default: out = '0;   // unused codes
        endcase
    end

    assign flag_zero_out = (out == 4'd0);

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
`default_nettype none

module alu_exec (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 start,
    input  wire types::alu_op   op,
    input  wire                 use_carry,
    input  wire types::nibble_t opnd_a,
    input  wire types::nibble_t opnd_b,
    input  wire                 carry_in,
    input  wire                 decimal_in,

    output logic                busy,
    output logic                wb_result_valid,
    output types::nibble_t      result,
    output logic                wb_flags_valid,
    output logic                carry_out,
    output logic                zero_out
);

    types::exec_state_t state;

    types::alu_op       op_q;
    logic               use_carry_q;
    types::nibble_t     a_q;
    types::nibble_t     b_q;
    logic               carry_q;
    logic               decimal_q;

    types::nibble_t     alu_out;
    logic               alu_carry;
    logic               alu_zero;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= types::EXEC_IDLE;
        end else begin
            case (state)
                types::EXEC_IDLE:  if (start) state <= types::EXEC_RUN;
                types::EXEC_RUN:   state <= types::EXEC_WRITE;
                types::EXEC_WRITE: state <= types::EXEC_IDLE;
                default:           state <= types::EXEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == types::EXEC_IDLE && start) begin
            op_q        <= op;          // snapshot of the command
            use_carry_q <= use_carry;
            a_q         <= opnd_a;
            b_q         <= opnd_b;
            carry_q     <= carry_in;
            decimal_q   <= decimal_in;
        end
        if (state == types::EXEC_RUN) begin
            result    <= alu_out;
            carry_out <= alu_carry;
            zero_out  <= alu_zero;
        end
    end

    alu u_alu (
        .op              (op_q),
        .op_use_carry    (use_carry_q),
        .temp_a          (a_q),
        .temp_b          (b_q),
        .flag_carry_in   (carry_q),
        .flag_decimal_in (decimal_q),
        .out             (alu_out),
        .flag_carry_out  (alu_carry),
        .flag_zero_out   (alu_zero)
    );

    assign busy            = (state != types::EXEC_IDLE);
    assign wb_flags_valid  = (state == types::EXEC_WRITE);
    assign wb_result_valid = (state == types::EXEC_WRITE) && (op_q != types::ALU_CP); // CP keeps dst

endmodule

`default_nettype wire

//--- rtl/alu_regs.sv
`default_nettype none
`include "alu_defs.svh"

module alu_regs (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire  [`ALU_WB_ADR_W-1:0]  wb_adr,
    input  wire  [`ALU_WB_DAT_W-1:0]  wb_dat_w,
    output logic [`ALU_WB_DAT_W-1:0]  wb_dat_r,
    output logic                      wb_ack,

    output logic                      start,
    output types::alu_op              op,
    output logic                      use_carry,
    output types::nibble_t            opnd_a,
    output types::nibble_t            opnd_b,
    output logic                      carry_in,
    output logic                      decimal_in,

    input  wire                       busy,
    input  wire                       wb_result_valid,
    input  wire  types::nibble_t      result,
    input  wire                       wb_flags_valid,
    input  wire                       carry_out,
    input  wire                       zero_out
);

    types::nibble_t  regs [4];     // r0 to r3
    types::flags_t   flags;
    types::alu_op    op_q;
    logic            use_carry_q;
    types::reg_idx_t dst_q;
    types::reg_idx_t src_q;

    logic            bus_req;
    logic            cmd_wr;
    logic            stall;
    logic            bus_wr;
    types::reg_idx_t dst_sel;
    types::reg_idx_t src_sel;

    assign bus_req = wb_cyc & wb_stb;
    assign cmd_wr  = bus_req & wb_we & (wb_adr == `ALU_ADR_CMD);
    assign stall   = cmd_wr & busy;            // hold off a new command
    assign bus_wr  = wb_ack & bus_req & wb_we; // write lands on the ack edge
    assign start   = wb_ack & cmd_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req & ~wb_ack & ~stall; // single cycle ack
        end
    end

    // the command is stored on the same edge that the sequencer samples it,
    // so during start the fields come straight from the bus
    assign op        = start ? types::alu_op'(wb_dat_w[`ALU_CMD_OP_LSB +: 4]) : op_q;
    assign use_carry = start ? wb_dat_w[`ALU_CMD_USE_CARRY] : use_carry_q;
    assign dst_sel   = start ? wb_dat_w[`ALU_CMD_DST_LSB +: 2] : dst_q;
    assign src_sel   = start ? wb_dat_w[`ALU_CMD_SRC_LSB +: 2] : src_q;

    assign opnd_a     = regs[dst_sel];
    assign opnd_b     = regs[src_sel];
    assign carry_in   = flags[`ALU_FLAG_CARRY];
    assign decimal_in = flags[`ALU_FLAG_DECIMAL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            flags       <= '0;
            op_q        <= types::ALU_ADD;
            use_carry_q <= 1'b0;
            dst_q       <= '0;
            src_q       <= '0;
        end else begin
            if (bus_wr && wb_adr < `ALU_ADR_FLAGS) begin
                regs[wb_adr[1:0]] <= wb_dat_w[3:0];
            end
            if (bus_wr && wb_adr == `ALU_ADR_FLAGS) begin
                flags <= wb_dat_w[2:0];
            end
            if (start) begin
                op_q        <= op;
                use_carry_q <= use_carry;
                dst_q       <= dst_sel;
                src_q       <= src_sel;
            end
            // write-back comes last so it wins over a host write
            if (wb_result_valid) begin
                regs[dst_q] <= result;
            end
            if (wb_flags_valid) begin
                flags[`ALU_FLAG_CARRY] <= carry_out;
                flags[`ALU_FLAG_ZERO]  <= zero_out;
            end
        end
    end

    always_comb begin
        wb_dat_r = '0;
        if (wb_adr < `ALU_ADR_FLAGS) begin
            wb_dat_r[3:0] = regs[wb_adr[1:0]];
        end else begin
            case (wb_adr)
                `ALU_ADR_FLAGS: wb_dat_r[2:0] = flags;
                `ALU_ADR_CMD: begin
                    wb_dat_r[`ALU_CMD_OP_LSB +: 4]  = op_q;
                    wb_dat_r[`ALU_CMD_USE_CARRY]    = use_carry_q;
                    wb_dat_r[`ALU_CMD_DST_LSB +: 2] = dst_q;
                    wb_dat_r[`ALU_CMD_SRC_LSB +: 2] = src_q;
                end
                `ALU_ADR_STATUS: wb_dat_r[`ALU_STATUS_BUSY] = busy;
                default: wb_dat_r = '0;   // unmapped reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu_core_top.sv
`default_nettype none
`include "alu_defs.svh"

module alu_core_top (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire [`ALU_WB_ADR_W-1:0]  wb_adr,
    input  wire [`ALU_WB_DAT_W-1:0]  wb_dat_w,
    output wire [`ALU_WB_DAT_W-1:0]  wb_dat_r,
    output wire                      wb_ack
);

    logic           start;
    types::alu_op   op;
    logic           use_carry;
    types::nibble_t opnd_a;
    types::nibble_t opnd_b;
    logic           carry_in;
    logic           decimal_in;

    logic           busy;
    logic           wb_result_valid;
    types::nibble_t result;
    logic           wb_flags_valid;
    logic           carry_out;
    logic           zero_out;

    alu_regs u_regs (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .start (start), .op (op), .use_carry (use_carry),
        .opnd_a (opnd_a), .opnd_b (opnd_b),
        .carry_in (carry_in), .decimal_in (decimal_in),
        .busy (busy), .wb_result_valid (wb_result_valid), .result (result),
        .wb_flags_valid (wb_flags_valid), .carry_out (carry_out), .zero_out (zero_out)
    );

    alu_exec u_exec (
        .clk (clk), .rst (rst),
        .start (start), .op (op), .use_carry (use_carry),
        .opnd_a (opnd_a), .opnd_b (opnd_b),
        .carry_in (carry_in), .decimal_in (decimal_in),
        .busy (busy), .wb_result_valid (wb_result_valid), .result (result),
        .wb_flags_valid (wb_flags_valid), .carry_out (carry_out), .zero_out (zero_out)
    );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;   // held through the first cycles
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_alu_core.sv
`default_nettype none
`include "alu_defs.svh"

module tb_alu_core;

    logic                     clk;
    logic                     rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`ALU_WB_ADR_W-1:0] wb_adr;
    logic [`ALU_WB_DAT_W-1:0] wb_dat_w;
    wire  [`ALU_WB_DAT_W-1:0] wb_dat_r;
    wire                      wb_ack;

    logic [35:0] vectors [$];        // nine hex fields per line
    logic [31:0] lfsr_state = 32'h52a;
    int          ack_waits;          // cycles spent waiting for the last ack
    int          cycles = 0;
    int          limit = 0;

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(10)) u_clk_gen (.clk(clk), .rst(rst));

    alu_core_top u_dut (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        report_failure($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_nibble(input string name, input types::nibble_t exp,
                                input types::nibble_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_flags(input string name, input types::flags_t exp,
                               input types::flags_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_word(input string name, input logic [`ALU_WB_DAT_W-1:0] exp,
                              input logic [`ALU_WB_DAT_W-1:0] act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            report_failure($sformatf("timeout: run did not finish within %0d cycles", limit));
        end
    end

    task automatic wb_write(input logic [`ALU_WB_ADR_W-1:0] adr,
                            input logic [`ALU_WB_DAT_W-1:0] dat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        ack_waits = 0;
        do begin
            @(negedge clk);   // ack is a register, stable here
            ack_waits++;
        end while (wb_ack !== 1'b1);
        @(posedge clk);       // the write lands on this edge
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`ALU_WB_ADR_W-1:0] adr,
                           output logic [`ALU_WB_DAT_W-1:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do begin
            @(negedge clk);
        end while (wb_ack !== 1'b1);
        dat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    function automatic logic [`ALU_WB_DAT_W-1:0] cmd_word(input types::alu_op op,
            input logic uc, input types::reg_idx_t dst, input types::reg_idx_t src);
        logic [`ALU_WB_DAT_W-1:0] cmd;
        cmd = '0;
        cmd[`ALU_CMD_OP_LSB +: 4]  = op;
        cmd[`ALU_CMD_USE_CARRY]    = uc;
        cmd[`ALU_CMD_DST_LSB +: 2] = dst;
        cmd[`ALU_CMD_SRC_LSB +: 2] = src;
        return cmd;
    endfunction

    task automatic wait_idle();
        logic [`ALU_WB_DAT_W-1:0] st;
        st = '1;
        while (st[`ALU_STATUS_BUSY] !== 1'b0) begin
            wb_read(`ALU_ADR_STATUS, st);
        end
    endtask

    task automatic check_reset_state();
        logic [`ALU_WB_DAT_W-1:0] d;
        logic [15:0]              r;
        types::nibble_t           wr [4];
        for (int i = 0; i < 4; i++) begin
            wb_read(3'(i), d);
            check_word($sformatf("r%0d", i), '0, d);
        end
        wb_read(`ALU_ADR_FLAGS, d);
        check_flags("flags", '0, d[2:0]);
        wb_read(`ALU_ADR_STATUS, d);
        check_status("busy", 1'b0, d[`ALU_STATUS_BUSY]);
        for (int i = 0; i < 4; i++) begin
            rand_bits(16, r);   // upper bits random too
            wr[i] = r[3:0];
            wb_write(3'(i), r);
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(3'(i), d);
            check_word($sformatf("r%0d", i), {12'h000, wr[i]}, d);
        end
        rand_bits(16, r);
        wb_write(`ALU_ADR_FLAGS, r);
        wb_read(`ALU_ADR_FLAGS, d);
        check_word("flags", {13'h0000, r[2:0]}, d);
    endtask

    task automatic run_vector(input logic [35:0] v);
        types::alu_op             op;
        types::nibble_t           a;
        types::nibble_t           b;
        types::nibble_t           exp_out;
        types::reg_idx_t          dst;
        types::reg_idx_t          src;
        logic [15:0]              r;
        logic [`ALU_WB_DAT_W-1:0] d;
        op      = types::alu_op'(v[35:32]);
        a       = v[27:24];
        b       = v[23:20];
        exp_out = v[11:8];
        rand_bits(4, r);
        dst = r[1:0];
        src = dst + 2'(r[3:2] % 3) + 2'd1;   // always a different register
        wb_write({1'b0, dst}, {12'h000, a});
        wb_write({1'b0, src}, {12'h000, b});
        rand_bits(3, r);
        wb_write(`ALU_ADR_FLAGS, {13'h0000, v[12], r[0], v[16]});  // stale zero flag
        repeat (r[2:1]) @(posedge clk);
        wb_write(`ALU_ADR_CMD, cmd_word(op, v[28], dst, src));
        wait_idle();
        wb_read({1'b0, dst}, d);
        check_nibble($sformatf("r%0d", dst), exp_out, d[3:0]);
        wb_read({1'b0, src}, d);
        check_nibble($sformatf("r%0d", src), b, d[3:0]);
        wb_read(`ALU_ADR_FLAGS, d);
        check_flags("flags", {v[12], v[0], v[4]}, d[2:0]);
    endtask

    task automatic check_back_to_back();
        logic [15:0]              r;
        logic [4:0]               sum;
        types::nibble_t           x;
        logic [`ALU_WB_DAT_W-1:0] d;
        rand_bits(12, r);
        wb_write(3'd0, {12'h000, r[3:0]});
        wb_write(3'd1, {12'h000, r[7:4]});
        wb_write(3'd2, {12'h000, r[11:8]});
        wb_write(`ALU_ADR_FLAGS, '0);
        // r0 += r1, then r2 ^= r0 while the add is still running
        wb_write(`ALU_ADR_CMD, cmd_word(types::ALU_ADD, 1'b0, 2'd0, 2'd1));
        wb_write(`ALU_ADR_CMD, cmd_word(types::ALU_XOR, 1'b0, 2'd2, 2'd0));
        if (ack_waits < 3) begin
            report_failure("second command was acknowledged while the first was busy");
        end
        wait_idle();
        sum = r[3:0] + r[7:4];
        x   = r[11:8] ^ sum[3:0];
        wb_read(3'd0, d);
        check_nibble("r0", sum[3:0], d[3:0]);
        wb_read(3'd2, d);
        check_nibble("r2", x, d[3:0]);
        wb_read(`ALU_ADR_FLAGS, d);
        check_flags("flags", {1'b0, x == 4'd0, sum[4]}, d[2:0]);  // xor keeps the add carry
        wb_read(`ALU_ADR_STATUS, d);
        check_status("busy", 1'b0, d[`ALU_STATUS_BUSY]);
    endtask

    initial begin : main
        int          fd;
        int          n;
        logic [3:0]  f [9];
        logic [639:0] line;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        fd = $fopen("dv/alu_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("could not open dv/alu_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n == 9) begin
                vectors.push_back({f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]});
            end else begin
                void'($fgets(line, fd));   // comment line
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            report_failure("the vectors file holds no test cases");
        end
        limit = vectors.size() * 80 + 400;
        @(negedge rst);
        check_reset_state();
        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end
        check_back_to_back();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/alu_vectors.txt
# columns: op use_carry a b carry decimal exp_dst exp_carry exp_zero (hex)
# op codes 0 add 1 sub 2 cp 3 and 4 or 5 xor 6 rrc 7 rlc 8 not, cp expects dst unchanged
0 0 3 4 0 0 7 0 0
0 0 9 8 0 0 1 1 0
0 0 8 8 1 0 0 1 1
0 1 8 7 1 0 0 1 1
0 1 5 6 1 0 c 0 0
0 1 f f 1 0 f 1 0
0 0 0 0 0 0 0 0 1
0 1 e 1 0 0 f 0 0
1 0 9 4 0 0 5 0 0
1 0 4 9 0 0 b 1 0
1 1 7 3 1 0 3 0 0
1 1 5 5 1 0 f 1 0
1 0 6 6 1 0 0 0 1
1 1 0 f 0 0 1 1 0
0 0 5 4 0 1 9 0 0
0 0 5 5 0 1 0 1 1
0 0 9 8 0 1 7 1 0
0 1 9 9 1 1 9 1 0
0 1 4 5 1 1 0 1 1
0 0 2 3 1 1 5 0 0
1 0 8 3 0 1 5 0 0
1 0 3 8 0 1 5 1 0
1 1 2 2 1 1 9 1 0
1 1 9 2 1 1 6 0 0
1 0 0 1 0 1 9 1 0
1 0 7 7 0 1 0 0 1
3 0 c a 1 0 8 1 0
3 0 5 a 0 0 0 0 1
4 0 5 a 0 0 f 0 0
4 1 0 0 1 0 0 1 1
5 0 6 3 1 0 5 1 0
5 0 9 9 0 1 0 0 1
8 0 5 3 1 0 a 1 0
8 0 f 0 0 0 0 0 1
6 0 9 0 0 0 4 1 0
6 0 2 0 1 0 9 0 0
6 0 1 0 0 0 0 1 1
6 0 e 0 1 1 f 0 0
7 0 9 0 0 0 2 1 0
7 0 4 0 1 0 9 0 0
7 0 8 0 0 0 0 1 1
7 1 7 0 1 0 f 0 0
2 0 7 3 0 0 7 0 0
2 0 5 5 0 0 5 0 1
2 0 3 8 0 0 3 1 0
2 1 6 6 1 0 6 0 1
2 0 3 8 0 1 3 1 0

//--- tb.f
+incdir+rtl
rtl/types.sv
rtl/alu.sv
rtl/alu_exec.sv
rtl/alu_regs.sv
rtl/alu_core_top.sv
dv/tb_clk_gen.sv
dv/tb_alu_core.sv

//--- Bender.yml
package:
  name: alu_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/types.sv
      - rtl/alu.sv
      - rtl/alu_exec.sv
      - rtl/alu_regs.sv
      - rtl/alu_core_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_alu_core.sv
